// ==== src.f ====
hdl/ps2_pkg.sv
hdl/ps2_frame_rx.sv
hdl/ps2_key_ctrl.sv
hdl/ps2_ascii_map.sv
hdl/ps2_keyboard.sv
bench/tb_clk_gen.sv
bench/tb_ps2_keyboard.sv

// ==== bench/tb_ps2_keyboard.sv ====
`timescale 1ns/1ps

module tb_ps2_keyboard;

  // one row of the stimulus table
  typedef struct packed {
    logic [2:0]          test;
    logic [7:0]          data;
    logic                bad_par;
    logic [3:0]          nbits;
    // 0 silent, 1 key event, 2 frame error
    logic [1:0]          kind;
    ps2_pkg::key_event_t exp_evt;
  } row_t;

  logic                clk;
  logic                arst_n;
  logic                ps2_clk;
  logic                ps2_data;
  logic                key_valid;
  logic                frame_err;
  ps2_pkg::key_event_t key_event;

  row_t                rows[$];
  int                  errors;
  int                  test_errs;
  // strobe counts and last event of the current row
  int                  n_evt;
  int                  n_err;
  ps2_pkg::key_event_t got;

  tb_clk_gen i_clk_gen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  ps2_keyboard i_ps2_keyboard (
    .clk       (clk),
    .arst_n    (arst_n),
    .ps2_clk   (ps2_clk),
    .ps2_data  (ps2_data),
    .key_valid (key_valid),
    .key_event (key_event),
    .frame_err (frame_err)
  );

  // outputs sampled at the falling edge of clk
  always @(negedge clk) begin
    if (key_valid) begin
      n_evt++;
      got = key_event;
    end
    if (frame_err) begin
      n_err++;
    end
  end

  // --------------------
  // helpers
  // --------------------

  // n rising edges plus the 2 ns drive offset
  task automatic wait_clk(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic add_row(input int test, input logic [7:0] data, input logic bad,
                         input int nbits, input int kind, input logic [7:0] ascii,
                         input logic ext, input logic rel);
    row_t row;
    row.test    = test[2:0];
    row.data    = data;
    row.bad_par = bad;
    row.nbits   = nbits[3:0];
    row.kind    = kind[1:0];
    row.exp_evt = '{scan_code: data, ascii: ascii, extended: ext, released: rel};
    rows.push_back(row);
  endtask

  task automatic check(input string name, input logic [31:0] expv, input logic [31:0] actv);
    if (expv !== actv) begin
      $display("** Error %s: expected %h, actual %h", name, expv, actv);
      errors++;
      test_errs++;
    end
  endtask

  // keyboard model sending start, data lsb first, odd parity and stop
  task automatic send_frame(input logic [7:0] data, input logic bad, input int nbits);
    logic [10:0] frame;
    frame = {1'b1, (~^data) ^ bad, data, 1'b0};
    for (int i = 0; i < nbits; i++) begin
      ps2_data = frame[i];
      // half period of 10 clk cycles each way
      wait_clk(10);
      ps2_clk = 1'b0;
      wait_clk(10);
      ps2_clk = 1'b1;
    end
    ps2_data = 1'b1;
  endtask

  // either strobe ends the wait
  // silent bytes run the full window
  task automatic wait_strobe(input logic expect_one, input logic [7:0] data);
    int i;
    i = 0;
    while (i < 200 && n_evt == 0 && n_err == 0) begin
      @(negedge clk);
      i++;
    end
    if (expect_one && n_evt == 0 && n_err == 0) begin
      $display("timeout: no key_valid or frame_err within 200 cycles after byte %h", data);
      errors++;
      test_errs++;
    end
  endtask

  // --------------------
  // stimulus
  // --------------------

  initial begin
    int i;
    ps2_clk   = 1'b1;
    ps2_data  = 1'b1;
    errors    = 0;
    test_errs = 0;
    n_evt     = 0;
    n_err     = 0;
    void'($urandom(4));

    // digit press and release
    add_row(1, 8'h16, 0, 11, 1, 8'h31, 0, 0);
    add_row(1, 8'hF0, 0, 11, 0, 8'h00, 0, 0);
    add_row(1, 8'h16, 0, 11, 1, 8'h31, 0, 1);
    // left shift held then released
    add_row(2, 8'h12, 0, 11, 1, 8'h00, 0, 0);
    add_row(2, 8'h16, 0, 11, 1, 8'h21, 0, 0);
    add_row(2, 8'h1C, 0, 11, 1, 8'h41, 0, 0);
    add_row(2, 8'hF0, 0, 11, 0, 8'h00, 0, 0);
    add_row(2, 8'h12, 0, 11, 1, 8'h00, 0, 1);
    add_row(2, 8'h1C, 0, 11, 1, 8'h61, 0, 0);
    // caps on, shift inverting it, then caps off
    add_row(3, 8'h58, 0, 11, 1, 8'h00, 0, 0);
    add_row(3, 8'h1C, 0, 11, 1, 8'h41, 0, 0);
    add_row(3, 8'h12, 0, 11, 1, 8'h00, 0, 0);
    add_row(3, 8'h1C, 0, 11, 1, 8'h61, 0, 0);
    add_row(3, 8'hF0, 0, 11, 0, 8'h00, 0, 0);
    add_row(3, 8'h12, 0, 11, 1, 8'h00, 0, 1);
    add_row(3, 8'h58, 0, 11, 1, 8'h00, 0, 0);
    add_row(3, 8'h1C, 0, 11, 1, 8'h61, 0, 0);
    add_row(3, 8'h5A, 0, 11, 1, 8'h0D, 0, 0);
    // extended make and break with silent prefixes
    add_row(4, 8'hE0, 0, 11, 0, 8'h00, 0, 0);
    add_row(4, 8'h75, 0, 11, 1, 8'h00, 1, 0);
    add_row(4, 8'hE0, 0, 11, 0, 8'h00, 0, 0);
    add_row(4, 8'hF0, 0, 11, 0, 8'h00, 0, 0);
    add_row(4, 8'h75, 0, 11, 1, 8'h00, 1, 1);
    // keypad enter shares 5A with enter yet carries no ascii
    add_row(4, 8'hE0, 0, 11, 0, 8'h00, 0, 0);
    add_row(4, 8'h5A, 0, 11, 1, 8'h00, 1, 0);
    add_row(4, 8'h66, 0, 11, 1, 8'h08, 0, 0);
    // bad parity followed by a clean frame
    add_row(5, 8'h1C, 1, 11, 2, 8'h00, 0, 0);
    add_row(5, 8'h1C, 0, 11, 1, 8'h61, 0, 0);
    // frame cut after 5 bits followed by a clean frame
    add_row(6, 8'h1C, 0, 5, 0, 8'h00, 0, 0);
    add_row(6, 8'h29, 0, 11, 1, 8'h20, 0, 0);

    i = 0;
    while (i < 20 && !arst_n) begin
      @(posedge clk);
      i++;
    end
    if (!arst_n) begin
      $display("reset never released");
      errors++;
    end
    wait_clk(5);

    for (int r = 0; r < rows.size(); r++) begin
      n_evt = 0;
      n_err = 0;
      send_frame(rows[r].data, rows[r].bad_par, int'(rows[r].nbits));
      wait_strobe(rows[r].kind != 2'd0, rows[r].data);
      check("key_valid count", rows[r].kind == 2'd1, n_evt);
      check("frame_err count", rows[r].kind == 2'd2, n_err);
      if (rows[r].kind == 2'd1 && n_evt == 1) begin
        check("key_event.scan_code", rows[r].exp_evt.scan_code, got.scan_code);
        check("key_event.ascii", rows[r].exp_evt.ascii, got.ascii);
        check("key_event.extended", rows[r].exp_evt.extended, got.extended);
        check("key_event.released", rows[r].exp_evt.released, got.released);
      end
      // partial frame needs the idle timeout to pass
      if (rows[r].nbits < 4'd11) begin
        wait_clk(int'(ps2_pkg::IDLE_TIMEOUT) + 50);
      end else begin
        wait_clk(20 + $urandom_range(0, 40));
      end
      if (r == rows.size() - 1 || rows[r + 1].test != rows[r].test) begin
        $display("test %0d finished with %0d errors", rows[r].test, test_errs);
        test_errs = 0;
      end
    end

    $display("6 tests, %0d rows, %0d errors", rows.size(), errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== bench/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic arst_n
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // reset low over the first 3 rising edges
  initial begin
    arst_n = 1'b0;
    repeat (3) @(posedge clk);
    #2 arst_n = 1'b1;
  end

endmodule

// ==== hdl/ps2_keyboard.sv ====
`timescale 1ns/1ps

module ps2_keyboard (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                ps2_clk,
  input  logic                ps2_data,
  output logic                key_valid,
  output ps2_pkg::key_event_t key_event,
  output logic                frame_err
);

  // frame_rx -> key_ctrl
  logic                byte_valid;
  logic [7:0]          rx_byte;
  // key_ctrl -> ascii_map
  logic                evt_strobe;
  ps2_pkg::key_event_t evt;
  ps2_pkg::key_mod_t   mods;

  ps2_frame_rx i_frame_rx (
    .clk        (clk),
    .arst_n     (arst_n),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .byte_valid (byte_valid),
    .rx_byte    (rx_byte),
    .frame_err  (frame_err)
  );

  ps2_key_ctrl i_key_ctrl (
    .clk        (clk),
    .arst_n     (arst_n),
    .byte_valid (byte_valid),
    .rx_byte    (rx_byte),
    .evt_strobe (evt_strobe),
    .evt        (evt),
    .mods       (mods)
  );

  ps2_ascii_map i_ascii_map (
    .clk        (clk),
    .arst_n     (arst_n),
    .evt_strobe (evt_strobe),
    .evt        (evt),
    .mods       (mods),
    .key_valid  (key_valid),
    .key_event  (key_event)
  );

endmodule

// ==== hdl/ps2_ascii_map.sv ====
`timescale 1ns/1ps

module ps2_ascii_map (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                evt_strobe,
  input  ps2_pkg::key_event_t evt,
  input  ps2_pkg::key_mod_t   mods,
  output logic                key_valid,
  output ps2_pkg::key_event_t key_event
);

  // lower-case letter, 00 if not a letter
  function automatic logic [7:0] letter_lc(input logic [7:0] sc);
    case (sc)
      8'h1C: letter_lc = 8'h61;
      8'h32: letter_lc = 8'h62;
      8'h21: letter_lc = 8'h63;
      8'h23: letter_lc = 8'h64;
      8'h24: letter_lc = 8'h65;
      8'h2B: letter_lc = 8'h66;
      8'h34: letter_lc = 8'h67;
      8'h33: letter_lc = 8'h68;
      8'h43: letter_lc = 8'h69;
      8'h3B: letter_lc = 8'h6A;
      8'h42: letter_lc = 8'h6B;
      8'h4B: letter_lc = 8'h6C;
      8'h3A: letter_lc = 8'h6D;
      8'h31: letter_lc = 8'h6E;
      8'h44: letter_lc = 8'h6F;
      8'h4D: letter_lc = 8'h70;
      8'h15: letter_lc = 8'h71;
      8'h2D: letter_lc = 8'h72;
      8'h1B: letter_lc = 8'h73;
      8'h2C: letter_lc = 8'h74;
      8'h3C: letter_lc = 8'h75;
      8'h2A: letter_lc = 8'h76;
      8'h1D: letter_lc = 8'h77;
      8'h22: letter_lc = 8'h78;
      8'h35: letter_lc = 8'h79;
      8'h1A: letter_lc = 8'h7A;
      default: letter_lc = 8'h00;
    endcase
  endfunction

  // digits follow shift alone, US symbols
  function automatic logic [7:0] other_code(input logic [7:0] sc, input logic shift);
    case (sc)
      8'h16: other_code = shift ? 8'h21 : 8'h31;
      8'h1E: other_code = shift ? 8'h40 : 8'h32;
      8'h26: other_code = shift ? 8'h23 : 8'h33;
      8'h25: other_code = shift ? 8'h24 : 8'h34;
      8'h2E: other_code = shift ? 8'h25 : 8'h35;
      8'h36: other_code = shift ? 8'h5E : 8'h36;
      8'h3D: other_code = shift ? 8'h26 : 8'h37;
      8'h3E: other_code = shift ? 8'h2A : 8'h38;
      8'h46: other_code = shift ? 8'h28 : 8'h39;
      8'h45: other_code = shift ? 8'h29 : 8'h30;
      // space, enter, backspace
      8'h29: other_code = 8'h20;
      8'h5A: other_code = 8'h0D;
      8'h66: other_code = 8'h08;
      default: other_code = 8'h00;
    endcase
  endfunction

  logic [7:0] lc;
  logic [7:0] ascii;

  always_comb begin
    lc = letter_lc(evt.scan_code);
    if (evt.extended) begin
      // extended keys carry no ascii
      ascii = 8'h00;
    end else if (lc != 8'h00) begin
      ascii = (mods.shift ^ mods.caps) ? (lc - 8'h20) : lc;
    end else begin
      ascii = other_code(evt.scan_code, mods.shift);
    end
  end

  // --------------------
  // output register
  // --------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      key_valid <= 1'b0;
    end else begin
      key_valid <= evt_strobe;
    end
  end

  always_ff @(posedge clk) begin
    if (evt_strobe) begin
      key_event <= '{scan_code: evt.scan_code, ascii: ascii,
                     extended: evt.extended, released: evt.released};
    end
  end

endmodule

// ==== hdl/ps2_key_ctrl.sv ====
`timescale 1ns/1ps

module ps2_key_ctrl (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                byte_valid,
  input  logic [7:0]          rx_byte,
  output logic                evt_strobe,
  output ps2_pkg::key_event_t evt,
  output ps2_pkg::key_mod_t   mods
);

  // pending prefix flags
  logic pend_ext;
  logic pend_brk;
  // one shift bit per side
  logic shift_l;
  logic shift_r;
  logic caps;

  // byte decode
  logic is_ext;
  logic is_brk;
  logic is_key;

  assign is_ext = (rx_byte == ps2_pkg::SC_EXTEND);
  assign is_brk = (rx_byte == ps2_pkg::SC_BREAK);
  // anything that is not a prefix ends the sequence
  assign is_key = byte_valid & ~is_ext & ~is_brk;

  // --------------------
  // prefix tracking
  // --------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pend_ext   <= 1'b0;
      pend_brk   <= 1'b0;
      evt_strobe <= 1'b0;
    end else begin
      evt_strobe <= is_key;
      if (byte_valid) begin
        if (is_ext) begin
          pend_ext <= 1'b1;
        end else if (is_brk) begin
          pend_brk <= 1'b1;
        end else begin
          // key byte consumes both flags
          pend_ext <= 1'b0;
          pend_brk <= 1'b0;
        end
      end
    end
  end

  // --------------------
  // modifiers
  // --------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      shift_l <= 1'b0;
      shift_r <= 1'b0;
      caps    <= 1'b0;
    end else if (is_key && !pend_ext) begin
      // make sets, break clears
      if (rx_byte == ps2_pkg::SC_LSHIFT) begin
        shift_l <= ~pend_brk;
      end
      if (rx_byte == ps2_pkg::SC_RSHIFT) begin
        shift_r <= ~pend_brk;
      end
      // caps toggles on make only
      if (rx_byte == ps2_pkg::SC_CAPS && !pend_brk) begin
        caps <= ~caps;
      end
    end
  end

  // --------------------
  // event payload
  // --------------------

  always_ff @(posedge clk) begin
    if (is_key) begin
      evt.scan_code <= rx_byte;
      // filled in downstream
      evt.ascii     <= 8'h00;
      evt.extended  <= pend_ext;
      evt.released  <= pend_brk;
    end
  end

  assign mods = '{shift: shift_l | shift_r, caps: caps};

  // bytes arrive 11 ps2 clocks apart, so events never touch
  a_evt_single : assert property (
    @(posedge clk) disable iff (!arst_n) evt_strobe |=> !evt_strobe
  );

endmodule

// ==== hdl/ps2_frame_rx.sv ====
`timescale 1ns/1ps

module ps2_frame_rx (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  output logic       byte_valid,
  output logic [7:0] rx_byte,
  output logic       frame_err
);

  // two-flop synchronizers, idle high
  logic [1:0] clk_sync;
  logic [1:0] dat_sync;
  // previous synced ps2 clock for edge detect
  logic       clk_prev;
  // registered falling-edge strobe
  logic       fall;

  logic [ps2_pkg::BIT_CNT_W-1:0] bit_cnt;
  logic [15:0]                   idle_cnt;
  logic [ps2_pkg::FRAME_BITS-1:0] frame_q;
  logic [ps2_pkg::FRAME_BITS-1:0] frame_nxt;
  logic                          frame_ok;

  // --------------------
  // sync and edge detect
  // --------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      clk_sync <= 2'b11;
      dat_sync <= 2'b11;
      clk_prev <= 1'b1;
      fall     <= 1'b0;
    end else begin
      clk_sync <= {clk_sync[0], ps2_clk};
      dat_sync <= {dat_sync[0], ps2_data};
      clk_prev <= clk_sync[1];
      // high-to-low on the synced line
      fall     <= clk_prev & ~clk_sync[1];
    end
  end

  // --------------------
  // frame shifter
  // --------------------

  // lsb first, so new bits enter at the top
  assign frame_nxt = {dat_sync[1], frame_q[ps2_pkg::FRAME_BITS-1:1]};

  // start low, stop high, odd parity over data + parity bit
  assign frame_ok = ~frame_nxt[0] & frame_nxt[ps2_pkg::FRAME_BITS-1] & (^frame_nxt[9:1]);

  always_ff @(posedge clk) begin
    if (fall) begin
      frame_q <= frame_nxt;
    end
  end

  // data byte sits in bits 8:1 once the stop bit is in
  assign rx_byte = frame_q[8:1];

  // --------------------
  // bit counter, idle timeout
  // --------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt    <= '0;
      idle_cnt   <= '0;
      byte_valid <= 1'b0;
      frame_err  <= 1'b0;
    end else begin
      // strobes by default
      byte_valid <= 1'b0;
      frame_err  <= 1'b0;
      if (fall) begin
        idle_cnt <= '0;
        if (bit_cnt == ps2_pkg::LAST_BIT) begin
          bit_cnt <= '0;
          // good frame -> byte, bad frame -> error
          if (frame_ok) begin
            byte_valid <= 1'b1;
          end else begin
            frame_err <= 1'b1;
          end
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end else if (idle_cnt == ps2_pkg::IDLE_TIMEOUT) begin
        // line quiet too long, drop partial frame
        bit_cnt <= '0;
      end else begin
        idle_cnt <= idle_cnt + 1'b1;
      end
    end
  end

  // counter wraps at the stop bit and never runs past it
  a_bit_cnt_range : assert property (
    @(posedge clk) disable iff (!arst_n) bit_cnt <= ps2_pkg::LAST_BIT
  );

endmodule

// ==== hdl/ps2_pkg.sv ====
package ps2_pkg;

  // --------------------
  // set-2 scan codes
  // --------------------

  // prefix bytes, never reported as events
  localparam logic [7:0] SC_EXTEND = 8'hE0;
  localparam logic [7:0] SC_BREAK = 8'hF0;

  // modifier keys
  localparam logic [7:0] SC_LSHIFT = 8'h12;
  localparam logic [7:0] SC_RSHIFT = 8'h59;
  localparam logic [7:0] SC_CAPS = 8'h58;

  // --------------------
  // frame timing
  // --------------------

  // clk cycles without a ps2 clock fall before a partial frame is dropped
  localparam logic [15:0] IDLE_TIMEOUT = 16'd2000;

  // start + 8 data + parity + stop
  localparam int FRAME_BITS = 11;
  localparam int BIT_CNT_W = $clog2(FRAME_BITS);
  // index of the stop bit
  localparam logic [BIT_CNT_W-1:0] LAST_BIT = BIT_CNT_W'(FRAME_BITS - 1);

  // --------------------
  // event types
  // --------------------

  // one key press or release, 18 bits
  typedef struct packed {
    logic [7:0] scan_code;
    logic [7:0] ascii;
    logic       extended;
    logic       released;
  } key_event_t;

  // modifier state at the time of an event
  typedef struct packed {
    logic shift;
    logic caps;
  } key_mod_t;

endpackage
